//--- hw/debug_module.sv
`default_nettype none

`include "dm_defs.svh"

module debug_module (
  input  logic                    dm_clk,
  input  logic                    dm_rst_n,
  // DTM side
  input  logic                    i_dtm_req_valid,
  output logic                    o_dtm_req_ready,
  input  dm_pkg::dtm_req_t        i_dtm_req,
  output logic                    o_dtm_resp_valid,
  input  logic                    i_dtm_resp_ready,
  output dm_pkg::dtm_resp_t       o_dtm_resp,
  // System bus side
  input  logic                    i_icb_cmd_valid,
  output logic                    o_icb_cmd_ready,
  input  dm_pkg::icb_cmd_t        i_icb_cmd,
  output logic                    o_icb_rsp_valid,
  input  logic                    i_icb_rsp_ready,
  output logic [31:0]             o_icb_rsp_rdata,
  // Debug interrupt per hart
  output logic [`DM_HART_NUM-1:0] o_dbg_irq
);

  dm_pkg::ram_port_t       dtm_ram;
  dm_pkg::ram_port_t       icb_ram;
  logic [31:0]             ram_rdata;
  logic                    dtm_grant;
  logic [`DM_HART_NUM-1:0] haltnot;
  dm_pkg::hart_evt_t       debint_set;
  dm_pkg::hart_evt_t       haltnot_clr;
  dm_pkg::hart_evt_t       debint_clr;
  dm_pkg::hart_evt_t       haltnot_set;

  // ==============================
  // Blocks
  // ==============================
  dm_dtm_regs u_dtm_regs (
    .dm_clk        (dm_clk),
    .dm_rst_n      (dm_rst_n),
    .i_req_valid   (i_dtm_req_valid),
    .i_req         (i_dtm_req),
    .i_resp_ready  (i_dtm_resp_ready),
    .i_ram_grant   (dtm_grant),
    .i_ram_rdata   (ram_rdata),
    .i_haltnot     (haltnot),
    .i_debint      (o_dbg_irq),
    .o_req_ready   (o_dtm_req_ready),
    .o_resp_valid  (o_dtm_resp_valid),
    .o_resp        (o_dtm_resp),
    .o_ram         (dtm_ram),
    .o_debint_set  (debint_set),
    .o_haltnot_clr (haltnot_clr)
  );

  dm_sysbus_agent u_sysbus_agent (
    .dm_clk        (dm_clk),
    .dm_rst_n      (dm_rst_n),
    .i_cmd_valid   (i_icb_cmd_valid),
    .i_cmd         (i_icb_cmd),
    .i_rsp_ready   (i_icb_rsp_ready),
    .i_ram_rdata   (ram_rdata),
    .o_cmd_ready   (o_icb_cmd_ready),
    .o_rsp_valid   (o_icb_rsp_valid),
    .o_rsp_rdata   (o_icb_rsp_rdata),
    .o_ram         (icb_ram),
    .o_debint_clr  (debint_clr),
    .o_haltnot_set (haltnot_set)
  );

  // debint vector doubles as the hart interrupt lines
  dm_halt_irq u_halt_irq (
    .dm_clk        (dm_clk),
    .dm_rst_n      (dm_rst_n),
    .i_debint_set  (debint_set),
    .i_debint_clr  (debint_clr),
    .i_haltnot_set (haltnot_set),
    .i_haltnot_clr (haltnot_clr),
    .o_haltnot     (haltnot),
    .o_debint      (o_dbg_irq)
  );

  dm_debug_ram u_debug_ram (
    .dm_clk      (dm_clk),
    .i_icb       (icb_ram),
    .i_dtm       (dtm_ram),
    .o_rdata     (ram_rdata),
    .o_dtm_grant (dtm_grant)
  );

endmodule

`default_nettype wire

//--- hw/dm_debug_ram.sv
`default_nettype none

`include "dm_defs.svh"

module dm_debug_ram (
  input  logic              dm_clk,
  input  dm_pkg::ram_port_t i_icb,
  input  dm_pkg::ram_port_t i_dtm,
  output logic [31:0]       o_rdata,
  output logic              o_dtm_grant
);

  logic [31:0]       mem_q [`DM_RAM_DEPTH];
  dm_pkg::ram_port_t sel;

  // ==============================
  // Arbitration
  // ==============================
  // System bus always wins
  assign o_dtm_grant = ~i_icb.en;

  // DTM side steers the address when the bus is idle
  assign sel = i_icb.en ? i_icb : i_dtm;

  // Read is asynchronous, so a write returns the old word
  assign o_rdata = mem_q[sel.addr];

  always_ff @(posedge dm_clk) begin
    if (sel.en & sel.we) begin
      mem_q[sel.addr] <= sel.wdata;
    end
  end

endmodule

`default_nettype wire

//--- hw/dm_defs.svh
`ifndef DM_DEFS_SVH
`define DM_DEFS_SVH

// ==============================
// Hart configuration
// ==============================
`define DM_HART_NUM         2
`define DM_HART_ID_W        1

// ==============================
// Port widths
// ==============================
`define DM_DTM_ADDR_W       5
`define DM_DTM_DATA_W       34
`define DM_ICB_ADDR_W       12
// Width of the hartid field inside dmcontrol
`define DM_HARTID_FIELD_W   10

// DTM register map
`define DM_ADDR_DMCONTROL   5'h10
`define DM_ADDR_DMINFO      5'h11
`define DM_ADDR_HALTSTAT    5'h1C

// System-bus register map
`define DM_ICB_CLEARDEBINT  12'h100
`define DM_ICB_SETHALTNOT   12'h10c
// Upper address nibble of the debug RAM window
`define DM_ICB_RAM_PAGE     4'h4

// Debug RAM geometry
`define DM_RAM_DEPTH        8
`define DM_RAM_AW           3

// ==============================
// dminfo fields
// ==============================
`define DM_DMINFO_RAMSIZE   6'd6
`define DM_DMINFO_AUTH      4'h0
`define DM_DMINFO_SERIAL    1'b1
`define DM_DMINFO_VERSION   2'd1
`define DM_DMINFO_VALUE     ({18'b0, `DM_DMINFO_RAMSIZE, `DM_DMINFO_AUTH, \
                              `DM_DMINFO_SERIAL, 3'b0, `DM_DMINFO_VERSION})

`endif

//--- hw/dm_dtm_regs.sv
`default_nettype none

`include "dm_defs.svh"

module dm_dtm_regs (
  input  logic                    dm_clk,
  input  logic                    dm_rst_n,
  input  logic                    i_req_valid,
  input  dm_pkg::dtm_req_t        i_req,
  input  logic                    i_resp_ready,
  input  logic                    i_ram_grant,
  input  logic [31:0]             i_ram_rdata,
  input  logic [`DM_HART_NUM-1:0] i_haltnot,
  input  logic [`DM_HART_NUM-1:0] i_debint,
  output logic                    o_req_ready,
  output logic                    o_resp_valid,
  output dm_pkg::dtm_resp_t       o_resp,
  output dm_pkg::ram_port_t       o_ram,
  output dm_pkg::hart_evt_t       o_debint_set,
  output dm_pkg::hart_evt_t       o_haltnot_clr
);

  logic                     op_rd;
  logic                     op_wr;
  logic                     sel_ram;
  logic                     sel_ctl;
  logic                     sel_info;
  logic                     sel_halt;
  logic                     stall;
  logic                     req_hsk;
  logic                     flag_wr;
  logic [`DM_HART_ID_W-1:0] hartid_q;
  logic                     cur_debint;
  logic                     cur_haltnot;
  dm_pkg::dtm_data_u        ctl_word;
  dm_pkg::dtm_data_u        ram_word;

  // ==============================
  // Request decode
  // ==============================
  assign op_rd = (i_req.op == dm_pkg::DTM_OP_READ);
  assign op_wr = (i_req.op == dm_pkg::DTM_OP_WRITE);

  // Nop and reserved select nothing, so they answer zero
  assign sel_ram  = (op_rd | op_wr) & (i_req.addr[4:3] == 2'b00);
  assign sel_ctl  = (op_rd | op_wr) & (i_req.addr == `DM_ADDR_DMCONTROL);
  assign sel_info = (op_rd | op_wr) & (i_req.addr == `DM_ADDR_DMINFO);
  assign sel_halt = (op_rd | op_wr) & (i_req.addr == `DM_ADDR_HALTSTAT);

  // RAM busy with the system bus this cycle
  assign stall = sel_ram & ~i_ram_grant;

  // Request and response finish together
  assign o_resp_valid = i_req_valid & ~stall;
  assign o_req_ready  = ~stall & i_resp_ready;
  assign req_hsk      = i_req_valid & o_req_ready;

  // ==============================
  // hartid register
  // ==============================
  always_ff @(posedge dm_clk or negedge dm_rst_n) begin
    if (!dm_rst_n) begin
      hartid_q <= '0;
    end else if (req_hsk & op_wr & sel_ctl) begin
      hartid_q <= i_req.data.dmcontrol_v.hartid[`DM_HART_ID_W-1:0];
    end
  end

  // Flags of the hart picked by hartid
  assign cur_debint  = i_debint[hartid_q];
  assign cur_haltnot = i_haltnot[hartid_q];

  // RAM access only on the handshake
  always_comb begin
    o_ram.en    = req_hsk & sel_ram;
    o_ram.we    = op_wr;
    o_ram.addr  = i_req.addr[`DM_RAM_AW-1:0];
    o_ram.wdata = i_req.data.dbgram_v.word;
  end

  // Flag bits sit at the same place in both views
  assign flag_wr = req_hsk & op_wr & (sel_ctl | sel_ram);

  // Interrupt is write-one-to-set
  assign o_debint_set.valid  = flag_wr & i_req.data.dmcontrol_v.interrupt;
  assign o_debint_set.id     = hartid_q;
  // haltnot is write-zero-to-clear
  assign o_haltnot_clr.valid = flag_wr & ~i_req.data.dmcontrol_v.haltnot;
  assign o_haltnot_clr.id    = hartid_q;

  // ==============================
  // Response data
  // ==============================
  always_comb begin
    ctl_word                       = '0;
    ctl_word.dmcontrol_v.interrupt = cur_debint;
    ctl_word.dmcontrol_v.haltnot   = cur_haltnot;
    ctl_word.dmcontrol_v.hartid    = `DM_HARTID_FIELD_W'(hartid_q);
    ram_word.dbgram_v.interrupt    = cur_debint;
    ram_word.dbgram_v.haltnot      = cur_haltnot;
    ram_word.dbgram_v.word         = i_ram_rdata;
  end

  always_comb begin
    o_resp.resp = 2'b00;
    o_resp.data = '0;
    if (sel_ctl) begin
      o_resp.data = ctl_word;
    end else if (sel_ram) begin
      o_resp.data = ram_word;
    end else if (sel_info) begin
      o_resp.data = `DM_DMINFO_VALUE;
    end else if (sel_halt) begin
      o_resp.data = `DM_DTM_DATA_W'(i_haltnot);
    end
  end

endmodule

`default_nettype wire

//--- hw/dm_halt_irq.sv
`default_nettype none

`include "dm_defs.svh"

module dm_halt_irq (
  input  logic                    dm_clk,
  input  logic                    dm_rst_n,
  input  dm_pkg::hart_evt_t       i_debint_set,
  input  dm_pkg::hart_evt_t       i_debint_clr,
  input  dm_pkg::hart_evt_t       i_haltnot_set,
  input  dm_pkg::hart_evt_t       i_haltnot_clr,
  output logic [`DM_HART_NUM-1:0] o_haltnot,
  output logic [`DM_HART_NUM-1:0] o_debint
);

  // ==============================
  // Per-hart flags
  // ==============================
  for (genvar i = 0; i < `DM_HART_NUM; i++) begin : g_hart
    localparam logic [`DM_HART_ID_W-1:0] HART_ID = `DM_HART_ID_W'(i);

    logic dbi_set;
    logic dbi_clr;
    logic hn_set;
    logic hn_clr;

    // Event hits only when it names this hart
    assign dbi_set = i_debint_set.valid  & (i_debint_set.id  == HART_ID);
    assign dbi_clr = i_debint_clr.valid  & (i_debint_clr.id  == HART_ID);
    assign hn_set  = i_haltnot_set.valid & (i_haltnot_set.id == HART_ID);
    assign hn_clr  = i_haltnot_clr.valid & (i_haltnot_clr.id == HART_ID);

    // Set beats clear in the same cycle
    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
      if (!dm_rst_n) begin
        o_debint[i]  <= 1'b0;
        o_haltnot[i] <= 1'b0;
      end else begin
        if (dbi_set | dbi_clr) begin
          o_debint[i] <= dbi_set;
        end
        if (hn_set | hn_clr) begin
          o_haltnot[i] <= hn_set;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/dm_pkg.sv
`default_nettype none

`include "dm_defs.svh"

package dm_pkg;

  // DTM operation code
  typedef enum logic [1:0] {
    DTM_OP_NOP   = 2'd0,
    DTM_OP_READ  = 2'd1,
    DTM_OP_WRITE = 2'd2,
    DTM_OP_RSVD  = 2'd3
  } dtm_op_e;

  // dmcontrol layout of the DTM data word
  typedef struct packed {
    logic                                interrupt;
    logic                                haltnot;
    logic [19:0]                         zero;
    logic [`DM_HARTID_FIELD_W-1:0]       hartid;
    logic [1:0]                          low;
  } dmcontrol_t;

  // Debug RAM layout, flag bits on top of a data word
  typedef struct packed {
    logic        interrupt;
    logic        haltnot;
    logic [31:0] word;
  } dbgram_t;

  // Same 34 bits, decoded by address
  typedef union packed {
    dmcontrol_t dmcontrol_v;
    dbgram_t    dbgram_v;
  } dtm_data_u;

  // ==============================
  // Port structs
  // ==============================
  typedef struct packed {
    logic [`DM_DTM_ADDR_W-1:0] addr;
    dtm_data_u                 data;
    dtm_op_e                   op;
  } dtm_req_t;

  typedef struct packed {
    logic [`DM_DTM_DATA_W-1:0] data;
    logic [1:0]                resp;
  } dtm_resp_t;

  typedef struct packed {
    logic [`DM_ICB_ADDR_W-1:0] addr;
    logic                      read;
    logic [31:0]               wdata;
  } icb_cmd_t;

  // One requester of the debug RAM
  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [`DM_RAM_AW-1:0] addr;
    logic [31:0]           wdata;
  } ram_port_t;

  // Set or clear request aimed at one hart
  typedef struct packed {
    logic                     valid;
    logic [`DM_HART_ID_W-1:0] id;
  } hart_evt_t;

endpackage

`default_nettype wire

//--- hw/dm_sysbus_agent.sv
`default_nettype none

`include "dm_defs.svh"

module dm_sysbus_agent (
  input  logic              dm_clk,
  input  logic              dm_rst_n,
  input  logic              i_cmd_valid,
  input  dm_pkg::icb_cmd_t  i_cmd,
  input  logic              i_rsp_ready,
  input  logic [31:0]       i_ram_rdata,
  output logic              o_cmd_ready,
  output logic              o_rsp_valid,
  output logic [31:0]       o_rsp_rdata,
  output dm_pkg::ram_port_t o_ram,
  output dm_pkg::hart_evt_t o_debint_clr,
  output dm_pkg::hart_evt_t o_haltnot_set
);

  logic                     cmd_hsk;
  logic                     cmd_wr;
  logic                     sel_clr;
  logic                     sel_set;
  logic                     sel_ram;
  logic [`DM_HART_ID_W-1:0] cleardebint_q;
  logic [`DM_HART_ID_W-1:0] sethaltnot_q;

  // Zero-cycle response, the command waits on response ready
  assign o_rsp_valid = i_cmd_valid;
  assign o_cmd_ready = i_rsp_ready;
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;
  assign cmd_wr      = cmd_hsk & ~i_cmd.read;

  // ==============================
  // Address decode
  // ==============================
  assign sel_clr = (i_cmd.addr == `DM_ICB_CLEARDEBINT);
  assign sel_set = (i_cmd.addr == `DM_ICB_SETHALTNOT);
  assign sel_ram = (i_cmd.addr[`DM_ICB_ADDR_W-1:`DM_ICB_ADDR_W-4] == `DM_ICB_RAM_PAGE);

  // Last hart ID written to each register
  always_ff @(posedge dm_clk or negedge dm_rst_n) begin
    if (!dm_rst_n) begin
      cleardebint_q <= '0;
      sethaltnot_q  <= '0;
    end else begin
      if (cmd_wr & sel_clr) begin
        cleardebint_q <= i_cmd.wdata[`DM_HART_ID_W-1:0];
      end
      if (cmd_wr & sel_set) begin
        sethaltnot_q <= i_cmd.wdata[`DM_HART_ID_W-1:0];
      end
    end
  end

  // Hart events carry the written ID directly
  assign o_debint_clr.valid  = cmd_wr & sel_clr;
  assign o_debint_clr.id     = i_cmd.wdata[`DM_HART_ID_W-1:0];
  assign o_haltnot_set.valid = cmd_wr & sel_set;
  assign o_haltnot_set.id    = i_cmd.wdata[`DM_HART_ID_W-1:0];

  // Word index from the byte address
  always_comb begin
    o_ram.en    = cmd_hsk & sel_ram;
    o_ram.we    = ~i_cmd.read;
    o_ram.addr  = i_cmd.addr[`DM_RAM_AW+1:2];
    o_ram.wdata = i_cmd.wdata;
  end

  // ROM window and holes read zero
  always_comb begin
    o_rsp_rdata = '0;
    if (sel_clr) begin
      o_rsp_rdata = 32'(cleardebint_q);
    end else if (sel_set) begin
      o_rsp_rdata = 32'(sethaltnot_q);
    end else if (sel_ram) begin
      o_rsp_rdata = i_ram_rdata;
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/dm_pkg.sv
hw/dm_dtm_regs.sv
hw/dm_sysbus_agent.sv
hw/dm_halt_irq.sv
hw/dm_debug_ram.sv
hw/debug_module.sv
tb/dm_properties.sv
tb/tb_debug_module.sv

//--- tb/dm_properties.sv
`default_nettype none

`include "dm_defs.svh"

module dm_properties (
  input logic                    dm_clk,
  input logic                    dm_rst_n,
  input logic                    i_icb_cmd_valid,
  input logic                    i_icb_rsp_valid,
  input logic                    i_dtm_req_valid,
  input logic                    i_dtm_req_ready,
  input logic                    i_dtm_resp_valid,
  input dm_pkg::dtm_resp_t       i_dtm_resp,
  input logic [`DM_HART_NUM-1:0] i_dbg_irq
);
  timeunit 1ns;
  timeprecision 100ps;

  // ==============================
  // Handshake rules
  // ==============================
  // Zero-cycle bus response
  a_icb_rsp_valid: assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
    i_icb_rsp_valid == i_icb_cmd_valid)
    else $error("o_icb_rsp_valid differs from i_icb_cmd_valid");

  // Accepted DTM request always has its response
  a_dtm_same_cycle: assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
    (i_dtm_req_valid && i_dtm_req_ready) |-> i_dtm_resp_valid)
    else $error("DTM request accepted without a valid response");

  a_dtm_resp_code: assert property (@(posedge dm_clk) disable iff (!dm_rst_n)
    i_dtm_resp.resp == 2'b00)
    else $error("DTM response code is not zero");

  // Interrupt lines quiet right out of reset
  a_irq_after_reset: assert property (@(posedge dm_clk)
    $rose(dm_rst_n) |-> (i_dbg_irq == '0))
    else $error("o_dbg_irq set in the first cycle after reset");

endmodule

bind debug_module dm_properties u_props (
  .dm_clk           (dm_clk),
  .dm_rst_n         (dm_rst_n),
  .i_icb_cmd_valid  (i_icb_cmd_valid),
  .i_icb_rsp_valid  (o_icb_rsp_valid),
  .i_dtm_req_valid  (i_dtm_req_valid),
  .i_dtm_req_ready  (o_dtm_req_ready),
  .i_dtm_resp_valid (o_dtm_resp_valid),
  .i_dtm_resp       (o_dtm_resp),
  .i_dbg_irq        (o_dbg_irq)
);

`default_nettype wire

//--- tb/tb_debug_module.sv
`default_nettype none

`include "dm_defs.svh"

module tb_debug_module;
  timeunit 1ns;
  timeprecision 100ps;

  // Port select and op codes used by the table
  localparam logic       DTM = 1'b0;
  localparam logic       SYS = 1'b1;
  localparam logic [1:0] NOP = 2'd0;
  localparam logic [1:0] RD  = 2'd1;
  localparam logic [1:0] WR  = 2'd2;
  localparam logic [1:0] RSV = 2'd3;

  // One stimulus row
  typedef struct packed {
    logic                    sys;
    logic [1:0]              op;
    logic [11:0]             addr;
    logic [33:0]             data;
    // RAM rows take a random data word and expect the model word
    logic                    rnd;
    logic                    chk;
    logic [33:0]             exp;
    logic [`DM_HART_NUM-1:0] irq;
    // Hold i_dtm_resp_ready low for two cycles
    logic                    bp;
  } row_t;

  logic                    dm_clk;
  logic                    dm_rst_n;
  logic                    i_dtm_req_valid;
  logic                    o_dtm_req_ready;
  dm_pkg::dtm_req_t        i_dtm_req;
  logic                    o_dtm_resp_valid;
  logic                    i_dtm_resp_ready;
  dm_pkg::dtm_resp_t       o_dtm_resp;
  logic                    i_icb_cmd_valid;
  logic                    o_icb_cmd_ready;
  dm_pkg::icb_cmd_t        i_icb_cmd;
  logic                    o_icb_rsp_valid;
  logic                    i_icb_rsp_ready;
  logic [31:0]             o_icb_rsp_rdata;
  logic [`DM_HART_NUM-1:0] o_dbg_irq;

  row_t        rows[$];
  logic [31:0] model [`DM_RAM_DEPTH];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  debug_module dut (.*);

  // ==============================
  // Clock and timeout
  // ==============================
  initial begin
    dm_clk = 1'b0;
    forever #10 dm_clk = ~dm_clk;
  end

  // Eight cycles per row plus margin for reset
  initial begin
    while (cycles < rows.size() * 8 + 20) begin
      @(posedge dm_clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycles);
    $display("Test failed");
    $finish;
  end

  // Interrupt in bit 33 and haltnot in bit 32 with hartid in bits 11:2
  function automatic logic [33:0] dmcontrol_word(input logic intr, input logic hn,
                                                 input int hart);
    return {intr, hn, 20'b0, 10'(hart), 2'b00};
  endfunction

  task automatic add_row(input logic sys, input logic [1:0] op, input logic [11:0] addr,
                         input logic [33:0] data, input logic rnd, input logic chk,
                         input logic [33:0] exp, input logic [`DM_HART_NUM-1:0] irq,
                         input logic bp);
    rows.push_back('{sys, op, addr, data, rnd, chk, exp, irq, bp});
  endtask

  task automatic check_value(input string name, input logic [33:0] act,
                             input logic [33:0] exp);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // ==============================
  // Row driver
  // ==============================
  task automatic apply_row(input row_t r);
    logic [2:0]  idx;
    logic [31:0] word;
    logic [33:0] exp;
    idx  = r.sys ? r.addr[4:2] : r.addr[2:0];
    word = r.rnd ? $urandom : r.data[31:0];
    // RAM rows answer the word held before this access
    exp  = r.rnd ? {r.exp[33:32], model[idx]} : r.exp;
    @(posedge dm_clk);
    if (r.sys) begin
      i_icb_cmd_valid <= 1'b1;
      i_icb_cmd.addr  <= r.addr;
      i_icb_cmd.read  <= (r.op == RD);
      i_icb_cmd.wdata <= word;
    end else begin
      i_dtm_req_valid <= 1'b1;
      i_dtm_req.addr  <= r.addr[4:0];
      i_dtm_req.data  <= {r.data[33:32], word};
      i_dtm_req.op    <= dm_pkg::dtm_op_e'(r.op);
      if (r.bp) begin
        i_dtm_resp_ready <= 1'b0;
      end
    end
    if (r.bp) begin
      // Response stays presented while the request is held off
      repeat (2) begin
        @(negedge dm_clk);
        check_value("o_dtm_req_ready", o_dtm_req_ready, 0);
        check_value("o_dtm_resp_valid", o_dtm_resp_valid, 1);
        check_value("o_dtm_resp.data", o_dtm_resp.data, exp);
      end
    end else begin
      @(negedge dm_clk);
      // Bus command ready follows response ready, which stays high
      if (r.sys) begin
        check_value("o_icb_cmd_ready", o_icb_cmd_ready, 1);
      end
      while (!(r.sys ? o_icb_cmd_ready : o_dtm_req_ready)) begin
        @(negedge dm_clk);
      end
      if (r.chk && r.sys) begin
        check_value("o_icb_rsp_rdata", {2'b00, o_icb_rsp_rdata}, exp);
      end else if (r.chk) begin
        check_value("o_dtm_resp.data", o_dtm_resp.data, exp);
      end
    end
    // State moves on the handshake edge
    @(posedge dm_clk);
    i_icb_cmd_valid  <= 1'b0;
    i_dtm_req_valid  <= 1'b0;
    i_dtm_resp_ready <= 1'b1;
    if (r.rnd && r.op == WR && !r.bp) begin
      model[idx] = word;
    end
    @(negedge dm_clk);
    check_value("o_dbg_irq", 34'(o_dbg_irq), 34'(r.irq));
  endtask

  // ==============================
  // Stimulus table
  // ==============================
  task automatic build_table();
    // Reset values and the constant dminfo
    add_row(DTM, RD, 12'h010, 34'h0, 0, 1, 34'h0, 2'b00, 0);
    add_row(DTM, RD, 12'h01C, 34'h0, 0, 1, 34'h0, 2'b00, 0);
    add_row(DTM, RD, 12'h011, 34'h0, 0, 1, `DM_DMINFO_VALUE, 2'b00, 0);
    // Select hart 1 and then raise its interrupt
    add_row(DTM, WR, 12'h010, dmcontrol_word(0, 1, 1), 0, 1, 34'h0, 2'b00, 0);
    add_row(DTM, WR, 12'h010, dmcontrol_word(1, 1, 1), 0, 1, dmcontrol_word(0, 0, 1),
            2'b10, 0);
    add_row(DTM, RD, 12'h010, 34'h0, 0, 1, dmcontrol_word(1, 0, 1), 2'b10, 0);
    // cleardebint drops it
    add_row(SYS, WR, 12'h100, 34'h1, 0, 0, 34'h0, 2'b00, 0);
    add_row(SYS, RD, 12'h100, 34'h0, 0, 1, 34'h1, 2'b00, 0);
    // sethaltnot and then a clear through dmcontrol
    add_row(SYS, WR, 12'h10c, 34'h1, 0, 0, 34'h0, 2'b00, 0);
    add_row(DTM, RD, 12'h01C, 34'h0, 0, 1, 34'h2, 2'b00, 0);
    add_row(DTM, RD, 12'h010, 34'h0, 0, 1, dmcontrol_word(0, 1, 1), 2'b00, 0);
    add_row(SYS, RD, 12'h10c, 34'h0, 0, 1, 34'h1, 2'b00, 0);
    add_row(DTM, WR, 12'h010, dmcontrol_word(0, 0, 1), 0, 1, dmcontrol_word(0, 1, 1),
            2'b00, 0);
    add_row(DTM, RD, 12'h01C, 34'h0, 0, 1, 34'h0, 2'b00, 0);
    // Debug RAM from both sides
    // The first DTM write meets an unwritten word
    add_row(DTM, WR, 12'h002, 34'h1_0000_0000, 1, 0, 34'h0, 2'b00, 0);
    add_row(SYS, RD, 12'h408, 34'h0, 1, 1, 34'h0, 2'b00, 0);
    add_row(SYS, WR, 12'h414, 34'h0, 1, 0, 34'h0, 2'b00, 0);
    add_row(DTM, RD, 12'h005, 34'h0, 1, 1, 34'h0, 2'b00, 0);
    add_row(DTM, WR, 12'h005, 34'h1_0000_0000, 1, 1, 34'h0, 2'b00, 0);
    add_row(DTM, RD, 12'h005, 34'h0, 1, 1, 34'h0, 2'b00, 0);
    add_row(SYS, RD, 12'h414, 34'h0, 1, 1, 34'h0, 2'b00, 0);
    // Back-pressure on a write that would set debint and clear haltnot
    add_row(SYS, WR, 12'h10c, 34'h1, 0, 0, 34'h0, 2'b00, 0);
    add_row(DTM, WR, 12'h002, 34'h2_0000_0000, 1, 1, 34'h1_0000_0000, 2'b00, 1);
    add_row(DTM, RD, 12'h002, 34'h0, 1, 1, 34'h1_0000_0000, 2'b00, 0);
    // Nop and reserved do nothing and the ROM window reads zero
    add_row(DTM, NOP, 12'h010, dmcontrol_word(1, 0, 0), 0, 1, 34'h0, 2'b00, 0);
    add_row(DTM, RSV, 12'h002, dmcontrol_word(1, 0, 0), 0, 1, 34'h0, 2'b00, 0);
    add_row(DTM, RD, 12'h010, 34'h0, 0, 1, dmcontrol_word(0, 1, 1), 2'b00, 0);
    add_row(SYS, RD, 12'h800, 34'h0, 0, 1, 34'h0, 2'b00, 0);
    add_row(SYS, RD, 12'h9fc, 34'h0, 0, 1, 34'h0, 2'b00, 0);
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    dm_rst_n         = 1'b0;
    i_dtm_req_valid  = 1'b0;
    i_dtm_req        = '0;
    i_dtm_resp_ready = 1'b1;
    i_icb_cmd_valid  = 1'b0;
    i_icb_cmd        = '0;
    i_icb_rsp_ready  = 1'b1;
    void'($urandom(7387));
    build_table();
    repeat (4) @(posedge dm_clk);
    dm_rst_n <= 1'b1;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    @(posedge dm_clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
